// ==== verilog/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    // RV32I base opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;

    // ALU operations
    localparam logic [3:0] alu_add  = 4'd0;
    localparam logic [3:0] alu_sub  = 4'd1;
    localparam logic [3:0] alu_and  = 4'd2;
    localparam logic [3:0] alu_or   = 4'd3;
    localparam logic [3:0] alu_xor  = 4'd4;
    localparam logic [3:0] alu_sll  = 4'd5;
    localparam logic [3:0] alu_srl  = 4'd6;
    localparam logic [3:0] alu_sra  = 4'd7;
    localparam logic [3:0] alu_slt  = 4'd8;
    localparam logic [3:0] alu_sltu = 4'd9;

    // Immediate formats
    localparam logic [2:0] imm_i = 3'd0;
    localparam logic [2:0] imm_s = 3'd1;
    localparam logic [2:0] imm_b = 3'd2;
    localparam logic [2:0] imm_u = 3'd3;
    localparam logic [2:0] imm_j = 3'd4;

    // Write-back sources
    localparam logic [1:0] wb_alu = 2'd0;
    localparam logic [1:0] wb_mem = 2'd1;
    localparam logic [1:0] wb_pc4 = 2'd2;
    localparam logic [1:0] wb_tgt = 2'd3;

    // Second adder sources
    // tgt_imm passes the immediate alone for lui
    localparam logic [1:0] tgt_pc  = 2'd0;
    localparam logic [1:0] tgt_rs1 = 2'd1;
    localparam logic [1:0] tgt_imm = 2'd2;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Three views of one instruction word
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

endpackage

`default_nettype wire

// ==== verilog/control.sv ====
`timescale 1ns/1ps
`default_nettype none

module control import core_pkg::*; (
    input  instr_u     instr,
    input  logic       alu_zero,
    input  logic       alu_neg,
    output logic [3:0] alu_op,
    output logic [2:0] imm_sel,
    output logic       alu_use_imm,
    output logic       mem_read,
    output logic       mem_write,
    output logic       reg_write,
    output logic [1:0] wb_sel,
    output logic [1:0] tgt_sel,
    output logic       take_target
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic [3:0] arith_op;
    logic       branch_taken;

    assign opcode = instr.r_fmt.opcode;
    assign funct3 = instr.r_fmt.funct3;

    // funct7[5] selects sub/sra, but only shifts look at it for immediates
    assign alt = instr.r_fmt.funct7[5] && (opcode == op_reg || funct3 == 3'b101);

    always_comb begin
        case (funct3)
            3'b000:  arith_op = alt ? alu_sub : alu_add;
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    // Branch outcome from the flags of rs1 - rs2
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = alu_zero;
            3'b001:  branch_taken = !alu_zero;
            3'b100:  branch_taken = alu_neg;
            3'b101:  branch_taken = !alu_neg;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        alu_op      = alu_add;
        imm_sel     = imm_i;
        alu_use_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        wb_sel      = wb_alu;
        tgt_sel     = tgt_pc;
        take_target = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op    = arith_op;
                reg_write = 1'b1;
            end
            op_imm: begin
                alu_op      = arith_op;
                alu_use_imm = 1'b1;
                reg_write   = 1'b1;
            end
            op_load: begin
                alu_use_imm = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
                wb_sel      = wb_mem;
            end
            op_store: begin
                imm_sel     = imm_s;
                alu_use_imm = 1'b1;
                mem_write   = 1'b1;
            end
            op_branch: begin
                imm_sel     = imm_b;
                alu_op      = alu_sub;
                take_target = branch_taken;
            end
            op_jal: begin
                imm_sel     = imm_j;
                reg_write   = 1'b1;
                wb_sel      = wb_pc4;
                take_target = 1'b1;
            end
            op_jalr: begin
                tgt_sel     = tgt_rs1;
                reg_write   = 1'b1;
                wb_sel      = wb_pc4;
                take_target = 1'b1;
            end
            op_lui: begin
                imm_sel   = imm_u;
                tgt_sel   = tgt_imm;
                reg_write = 1'b1;
                wb_sel    = wb_tgt;
            end
            op_auipc: begin
                imm_sel   = imm_u;
                reg_write = 1'b1;
                wb_sel    = wb_tgt;
            end
            default: begin
                // Unknown opcode writes nothing
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] wdata,
    input  logic            we,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 holds zero only through reset and the dropped writes
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

    x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rs1 == 5'd0) |-> (rdata1 == '0)
    ) else $error("regfile: x0 read back nonzero");

endmodule

`default_nettype wire

// ==== verilog/signext.sv ====
`timescale 1ns/1ps
`default_nettype none

module signext import core_pkg::*; (
    input  instr_u          instr,
    input  logic [2:0]      imm_sel,
    output logic [xlen-1:0] imm
);

    i_fmt_t i_v;
    s_fmt_t s_v;

    assign i_v = instr.i_fmt;
    assign s_v = instr.s_fmt;

    always_comb begin
        case (imm_sel)
            imm_s: imm = {{20{s_v.imm_hi[6]}}, s_v.imm_hi, s_v.imm_lo};
            // imm[12|10:5] in imm_hi, imm[4:1|11] in imm_lo
            imm_b: imm = {{20{s_v.imm_hi[6]}}, s_v.imm_lo[0], s_v.imm_hi[5:0],
                          s_v.imm_lo[4:1], 1'b0};
            imm_u: imm = {i_v.imm, i_v.rs1, i_v.funct3, 12'b0};
            // Instruction bits 31, 19:12, 20, 30:21
            imm_j: imm = {{12{i_v.imm[11]}}, i_v.rs1, i_v.funct3, i_v.imm[0],
                          i_v.imm[10:1], 1'b0};
            default: imm = {{20{i_v.imm[11]}}, i_v.imm};
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  logic [3:0]      alu_op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] result,
    output logic            zero,
    output logic            neg
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(xlen-1){1'b0}}, a < b};
            default:  result = '0;
        endcase
    end

    // Flags for branch resolution
    assign zero = (result == '0);
    assign neg  = result[xlen-1];

endmodule

`default_nettype wire

// ==== verilog/data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_mem import core_pkg::*; #(
    parameter int dmem_words = 256
) (
    input  logic            clk,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wdata,
    input  logic [2:0]      funct3,
    input  logic            read,
    input  logic            write,
    output logic [xlen-1:0] rdata
);

    localparam int aw = $clog2(dmem_words);

    logic [xlen-1:0] mem [dmem_words];
    logic [aw-1:0]   idx;
    logic [1:0]      lane;
    logic [3:0]      byte_en;
    logic [xlen-1:0] lane_data;
    logic [xlen-1:0] word;
    logic [7:0]      rd_byte;
    logic [15:0]     rd_half;

    assign idx  = addr[aw+1:2];
    assign lane = addr[1:0];
    assign word = mem[idx];

    // Replicate store data so every lane sees it, enables pick the lane
    always_comb begin
        case (funct3[1:0])
            2'b00: begin
                byte_en   = 4'b0001 << lane;
                lane_data = {4{wdata[7:0]}};
            end
            2'b01: begin
                byte_en   = 4'b0011 << {lane[1], 1'b0};
                lane_data = {2{wdata[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                lane_data = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

    assign rd_byte = word[{lane, 3'b000} +: 8];
    assign rd_half = word[{lane[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3)
            3'b000:  rdata = {{24{rd_byte[7]}}, rd_byte};
            3'b001:  rdata = {{16{rd_half[15]}}, rd_half};
            3'b100:  rdata = {24'b0, rd_byte};
            3'b101:  rdata = {16'b0, rd_half};
            default: rdata = word;
        endcase
        if (!read) begin
            rdata = '0;
        end
    end

    access_in_range: assert property (
        @(posedge clk) (read || write) |-> (addr[xlen-1:2] < dmem_words)
    ) else $error("data_mem: access outside memory at %h", addr);

    half_aligned: assert property (
        @(posedge clk) ((read || write) && funct3[1:0] == 2'b01) |-> !addr[0]
    ) else $error("data_mem: halfword access at odd address %h", addr);

endmodule

`default_nettype wire

// ==== verilog/core.sv ====
`timescale 1ns/1ps
`default_nettype none

module core import core_pkg::*; #(
    parameter int dmem_words = 256
) (
    input  logic            clk,
    input  logic            rst_n,
    output logic [xlen-1:0] instr_addr,
    input  logic [xlen-1:0] instr,
    output logic            wb_en,
    output logic [4:0]      wb_reg,
    output logic [xlen-1:0] wb_data
);

    instr_u          ins;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;
    logic [xlen-1:0] target;
    logic [xlen-1:0] rs1_sum;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] mem_rdata;
    logic            alu_zero;
    logic            alu_neg;
    logic [3:0]      alu_op;
    logic [2:0]      imm_sel;
    logic            alu_use_imm;
    logic            mem_read;
    logic            mem_write;
    logic            reg_write;
    logic [1:0]      wb_sel;
    logic [1:0]      tgt_sel;
    logic            take_target;

    assign ins        = instr;
    assign instr_addr = pc;
    assign pc_plus4   = pc + xlen'(4);

    // Second adder for branches, jumps, auipc and lui
    assign rs1_sum = rdata1 + imm;

    always_comb begin
        case (tgt_sel)
            tgt_rs1: target = {rs1_sum[xlen-1:1], 1'b0};
            tgt_imm: target = imm;
            default: target = pc + imm;
        endcase
    end

    assign pc_next = take_target ? target : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign alu_b = alu_use_imm ? imm : rdata2;

    always_comb begin
        case (wb_sel)
            wb_mem:  wb_data = mem_rdata;
            wb_pc4:  wb_data = pc_plus4;
            wb_tgt:  wb_data = target;
            default: wb_data = alu_result;
        endcase
    end

    // x0 writes are never reported
    assign wb_reg = ins.r_fmt.rd;
    assign wb_en  = reg_write && rst_n && (ins.r_fmt.rd != 5'd0);

    control u_control (
        .instr       (ins),
        .alu_zero    (alu_zero),
        .alu_neg     (alu_neg),
        .alu_op      (alu_op),
        .imm_sel     (imm_sel),
        .alu_use_imm (alu_use_imm),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .reg_write   (reg_write),
        .wb_sel      (wb_sel),
        .tgt_sel     (tgt_sel),
        .take_target (take_target)
    );

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .rs1    (ins.r_fmt.rs1),
        .rs2    (ins.r_fmt.rs2),
        .rd     (ins.r_fmt.rd),
        .wdata  (wb_data),
        .we     (wb_en),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    signext u_signext (
        .instr   (ins),
        .imm_sel (imm_sel),
        .imm     (imm)
    );

    alu u_alu (
        .alu_op (alu_op),
        .a      (rdata1),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero),
        .neg    (alu_neg)
    );

    data_mem #(
        .dmem_words (dmem_words)
    ) u_data_mem (
        .clk    (clk),
        .addr   (alu_result),
        .wdata  (rdata2),
        .funct3 (ins.r_fmt.funct3),
        .read   (mem_read),
        .write  (mem_write && rst_n),
        .rdata  (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== test/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam logic [6:0] opc_reg    = 7'b0110011;
    localparam logic [6:0] opc_imm    = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // addi x0, x0, 0
    localparam logic [31:0] nop = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] instr_addr;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;

    // Stimulus and expected values for each cycle
    logic [31:0] q_instr [$];
    logic        q_en    [$];
    logic [4:0]  q_reg   [$];
    logic [31:0] q_data  [$];
    logic [31:0] q_addr  [$];
    string       q_name  [$];

    int errors;
    int failed_rows;

    core #(
        .dmem_words (256)
    ) u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr      (instr),
        .wb_en      (wb_en),
        .wb_reg     (wb_reg),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_reg};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    // Branch offset in bytes with bit 0 dropped by the format
    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic void add_row(input logic [31:0] ins, input logic en,
                                    input logic [4:0] rd, input logic [31:0] data,
                                    input logic [31:0] addr, input string name);
        q_instr.push_back(ins);
        q_en.push_back(en);
        q_reg.push_back(rd);
        q_data.push_back(data);
        q_addr.push_back(addr);
        q_name.push_back(name);
    endfunction

    function automatic void build_table();
        // x1 = -5, x2 = 4, x4 = 0x12345678 feed the later rows
        add_row(enc_i(12'hffb, 5'd0, 3'd0, 5'd1, opc_imm), 1'b1, 5'd1, 32'hffff_fffb, 0, "addi");
        add_row(enc_i(12'hfff, 5'd1, 3'd4, 5'd2, opc_imm), 1'b1, 5'd2, 32'h0000_0004, 4, "xori");
        add_row(enc_i(12'hffc, 5'd1, 3'd2, 5'd3, opc_imm), 1'b1, 5'd3, 32'h0000_0001, 8, "slti");
        add_row(enc_u(20'h12345, 5'd4, opc_lui), 1'b1, 5'd4, 32'h1234_5000, 12, "lui");
        add_row(enc_i(12'h678, 5'd4, 3'd0, 5'd4, opc_imm), 1'b1, 5'd4, 32'h1234_5678, 16, "addi");
        add_row(enc_r(7'h00, 5'd1, 5'd4, 3'd0, 5'd5), 1'b1, 5'd5, 32'h1234_5673, 20, "add");
        add_row(enc_r(7'h20, 5'd2, 5'd4, 3'd0, 5'd6), 1'b1, 5'd6, 32'h1234_5674, 24, "sub");
        add_row(enc_r(7'h00, 5'd2, 5'd4, 3'd1, 5'd7), 1'b1, 5'd7, 32'h2345_6780, 28, "sll");
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd8), 1'b1, 5'd8, 32'h0fff_ffff, 32, "srl");
        add_row(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd9), 1'b1, 5'd9, 32'hffff_ffff, 36, "sra");
        add_row(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd10), 1'b1, 5'd10, 32'h0000_0001, 40, "sltu");
        add_row(enc_u(20'h00001, 5'd11, opc_auipc), 1'b1, 5'd11, 32'h0000_102c, 44, "auipc");
        // Memory round trips at byte addresses 16, 20 and 26
        add_row(enc_s(12'd16, 5'd4, 5'd0, 3'd2), 1'b0, 5'd0, 32'h0, 48, "sw");
        add_row(enc_i(12'd16, 5'd0, 3'd2, 5'd12, opc_load), 1'b1, 5'd12, 32'h1234_5678, 52, "lw");
        add_row(enc_s(12'd20, 5'd1, 5'd0, 3'd0), 1'b0, 5'd0, 32'h0, 56, "sb lane 0");
        add_row(enc_s(12'd21, 5'd2, 5'd0, 3'd0), 1'b0, 5'd0, 32'h0, 60, "sb lane 1");
        add_row(enc_s(12'd22, 5'd4, 5'd0, 3'd0), 1'b0, 5'd0, 32'h0, 64, "sb lane 2");
        add_row(enc_s(12'd23, 5'd3, 5'd0, 3'd0), 1'b0, 5'd0, 32'h0, 68, "sb lane 3");
        add_row(enc_i(12'd20, 5'd0, 3'd2, 5'd13, opc_load), 1'b1, 5'd13, 32'h0178_04fb, 72, "lw");
        add_row(enc_i(12'd20, 5'd0, 3'd0, 5'd14, opc_load), 1'b1, 5'd14, 32'hffff_fffb, 76, "lb");
        add_row(enc_i(12'd20, 5'd0, 3'd4, 5'd15, opc_load), 1'b1, 5'd15, 32'h0000_00fb, 80, "lbu");
        add_row(enc_s(12'd26, 5'd1, 5'd0, 3'd1), 1'b0, 5'd0, 32'h0, 84, "sh");
        add_row(enc_i(12'd26, 5'd0, 3'd1, 5'd16, opc_load), 1'b1, 5'd16, 32'hffff_fffb, 88, "lh");
        add_row(enc_i(12'd26, 5'd0, 3'd5, 5'd17, opc_load), 1'b1, 5'd17, 32'h0000_fffb, 92, "lhu");
        // The next row's address shows each branch outcome
        add_row(enc_b(13'd8, 5'd14, 5'd1, 3'd0), 1'b0, 5'd0, 32'h0, 96, "beq taken");
        add_row(enc_b(13'd8, 5'd2, 5'd1, 3'd0), 1'b0, 5'd0, 32'h0, 104, "beq not taken");
        add_row(enc_b(13'd12, 5'd2, 5'd1, 3'd1), 1'b0, 5'd0, 32'h0, 108, "bne taken");
        add_row(enc_b(13'd8, 5'd14, 5'd1, 3'd1), 1'b0, 5'd0, 32'h0, 120, "bne not taken");
        add_row(enc_b(13'd8, 5'd2, 5'd1, 3'd4), 1'b0, 5'd0, 32'h0, 124, "blt taken");
        add_row(enc_b(13'd8, 5'd1, 5'd2, 3'd4), 1'b0, 5'd0, 32'h0, 132, "blt not taken");
        add_row(enc_b(13'd16, 5'd1, 5'd2, 3'd5), 1'b0, 5'd0, 32'h0, 136, "bge taken");
        add_row(enc_b(13'd8, 5'd2, 5'd1, 3'd5), 1'b0, 5'd0, 32'h0, 152, "bge not taken");
        add_row(enc_j(21'd16, 5'd18), 1'b1, 5'd18, 32'd160, 156, "jal");
        add_row(enc_i(12'd201, 5'd0, 3'd0, 5'd19, opc_imm), 1'b1, 5'd19, 32'd201, 172, "addi");
        // 201 + 4 is odd, so the target lands on 204
        add_row(enc_i(12'd4, 5'd19, 3'd0, 5'd20, opc_jalr), 1'b1, 5'd20, 32'd180, 176, "jalr");
        add_row(enc_j(21'h1ffff8, 5'd0), 1'b0, 5'd0, 32'h0, 204, "jal back to x0");
        add_row(enc_i(12'd9, 5'd1, 3'd0, 5'd0, opc_imm), 1'b0, 5'd0, 32'h0, 196, "addi to x0");
        add_row(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd21), 1'b1, 5'd21, 32'd4, 200, "add from x0");
        add_row(enc_r(7'h20, 5'd1, 5'd0, 3'd0, 5'd22), 1'b1, 5'd22, 32'd5, 204, "sub from x0");
    endfunction

    task automatic check_row(input int i, output int errs);
        errs = 0;
        if (instr_addr !== q_addr[i]) begin
            $display("error: row %0d instr_addr expected %h got %h", i, q_addr[i], instr_addr);
            errs++;
        end
        if (wb_en !== q_en[i]) begin
            $display("error: row %0d wb_en expected %h got %h", i, q_en[i], wb_en);
            errs++;
        end
        // Register and data only mean something with the enable high
        if (q_en[i]) begin
            if (wb_reg !== q_reg[i]) begin
                $display("error: row %0d wb_reg expected %h got %h", i, q_reg[i], wb_reg);
                errs++;
            end
            if (wb_data !== q_data[i]) begin
                $display("error: row %0d wb_data expected %h got %h", i, q_data[i], wb_data);
                errs++;
            end
        end
    endtask

    initial begin
        #1;
        #((q_instr.size() + 10) * 20);
        $display("watchdog expired before all rows were applied");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int row_errs;
        rst_n       = 1'b0;
        instr       = nop;
        errors      = 0;
        failed_rows = 0;
        build_table();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < q_instr.size(); i++) begin
            instr = q_instr[i];
            // Sample just before the edge that commits this instruction
            #17;
            check_row(i, row_errs);
            if (row_errs == 0) begin
                $display("row %0d %s ok", i, q_name[i]);
            end else begin
                $display("row %0d %s failed with %0d error(s)", i, q_name[i], row_errs);
                errors += row_errs;
                failed_rows++;
            end
            @(posedge clk);
            #1;
        end
        $display("%0d rows run, %0d passed, %0d failed", q_instr.size(),
                 q_instr.size() - failed_rows, failed_rows);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
verilog/core_pkg.sv
verilog/control.sv
verilog/regfile.sv
verilog/signext.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/core.sv
test/tb_core.sv

// ==== Makefile ====
TOP := tb_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
